// ==== logic/video_pkg.sv ====
`default_nettype none

package video_pkg;

  // colour depth, split evenly over red, green and blue
  localparam int PIXEL_BITS = 12;
  localparam int CHAN_BITS = PIXEL_BITS / 3;

  // raster coordinates wide enough for the full blanking interval
  localparam int COORD_BITS = 4;

  // red in the top nibble, blue in the bottom one
  typedef logic [PIXEL_BITS-1:0] pixel_t;

  typedef logic [CHAN_BITS-1:0] chan_t;

  // x or y position in the raster or the frame
  typedef logic [COORD_BITS-1:0] coord_t;

endpackage

`default_nettype wire

// ==== logic/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

  localparam int ADDR_BITS = 8;
  localparam int DATA_BITS = 16;

  // word address, one pixel per word
  typedef logic [ADDR_BITS-1:0] addr_t;

  // pixel in the low bits, upper bits zero
  typedef logic [DATA_BITS-1:0] data_t;

  typedef logic [DATA_BITS/8-1:0] strb_t;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== logic/test_pattern_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module test_pattern_gen #(
  parameter int H_VISIBLE = 8,
  parameter int V_VISIBLE = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              swap,
  input  video_pkg::pixel_t pattern_base,
  input  logic              pix_ready,
  output logic              pix_valid,
  output axil_pkg::addr_t   pix_addr,
  output video_pkg::pixel_t pix_color,
  output logic              frame_last
);

  video_pkg::coord_t x;
  video_pkg::coord_t y;
  video_pkg::pixel_t base;
  video_pkg::pixel_t offset;
  logic              active;
  logic              last_pix;

  assign last_pix = (x == H_VISIBLE - 1) && (y == V_VISIBLE - 1);

  // row-major index doubles as the write address and the colour offset
  assign offset     = video_pkg::pixel_t'(y * H_VISIBLE + x);
  assign pix_addr   = axil_pkg::addr_t'(y * H_VISIBLE + x);
  assign pix_color  = base + offset;
  assign pix_valid  = active;
  assign frame_last = active && last_pix;

  always_ff @(posedge clk) begin
    if (reset || swap) begin
      // a new frame starts with the base that is current right now
      x      <= '0;
      y      <= '0;
      base   <= pattern_base;
      active <= 1'b1;
    end else if (pix_valid && pix_ready) begin
      if (last_pix) begin
        // frame done, wait for the buffers to change roles
        active <= 1'b0;
      end else if (x == H_VISIBLE - 1) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/fb_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fb_writer (
  input  logic              clk,
  input  logic              reset,
  input  logic              pix_valid,
  output logic              pix_ready,
  input  axil_pkg::addr_t   pix_addr,
  input  video_pkg::pixel_t pix_color,
  output axil_pkg::addr_t   prod_awaddr,
  output logic              prod_awvalid,
  input  logic              prod_awready,
  output axil_pkg::data_t   prod_wdata,
  output axil_pkg::strb_t   prod_wstrb,
  output logic              prod_wvalid,
  input  logic              prod_wready,
  input  logic              prod_bvalid,
  input  axil_pkg::resp_t   prod_bresp,
  output logic              prod_bready,
  output logic              wr_idle
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP
  } wr_state_t;

  wr_state_t         state;
  logic              aw_pend;
  logic              w_pend;
  axil_pkg::addr_t   addr_q;
  video_pkg::pixel_t color_q;
  logic              aw_done;
  logic              w_done;

  assign pix_ready    = (state == WR_IDLE);
  assign wr_idle      = (state == WR_IDLE);
  assign prod_awaddr  = addr_q;
  assign prod_awvalid = aw_pend;
  assign prod_wdata   = axil_pkg::data_t'(color_q);
  assign prod_wstrb   = '1;
  assign prod_wvalid  = w_pend;
  assign prod_bready  = (state == WR_RESP);

  // a channel counts as done once it has no handshake left to make
  assign aw_done = !aw_pend || prod_awready;
  assign w_done  = !w_pend || prod_wready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= WR_IDLE;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (pix_valid) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
            state   <= WR_SEND;
          end
        end
        WR_SEND: begin
          // address and data may be accepted in different cycles
          if (prod_awready) begin
            aw_pend <= 1'b0;
          end
          if (prod_wready) begin
            w_pend <= 1'b0;
          end
          if (aw_done && w_done) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          // every response is OKAY, so bresp carries nothing to act on
          if (prod_bvalid) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid && pix_ready) begin
      addr_q  <= pix_addr;
      color_q <= pix_color;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dbuf_mem_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dbuf_mem_ctrl #(
  parameter int FRAME_WORDS = 32
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            swap,
  input  axil_pkg::addr_t prod_awaddr,
  input  logic            prod_awvalid,
  output logic            prod_awready,
  input  axil_pkg::data_t prod_wdata,
  input  axil_pkg::strb_t prod_wstrb,
  input  logic            prod_wvalid,
  output logic            prod_wready,
  output logic            prod_bvalid,
  output axil_pkg::resp_t prod_bresp,
  input  logic            prod_bready,
  input  axil_pkg::addr_t cons_araddr,
  input  logic            cons_arvalid,
  output logic            cons_arready,
  output axil_pkg::data_t cons_rdata,
  output axil_pkg::resp_t cons_rresp,
  output logic            cons_rvalid,
  input  logic            cons_rready
);

  localparam int IDX_BITS = $clog2(FRAME_WORDS);

  axil_pkg::data_t bank0 [FRAME_WORDS];
  axil_pkg::data_t bank1 [FRAME_WORDS];

  // set when bank 1 is displayed and bank 0 is drawn into
  logic            front;
  logic            wr_fire;
  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] rd_idx;
  axil_pkg::data_t rd_word;

  // address and data are taken in the same cycle, once no B is waiting
  assign prod_awready = prod_awvalid && prod_wvalid && !prod_bvalid;
  assign prod_wready  = prod_awready;
  assign wr_fire      = prod_awready;
  assign prod_bresp   = axil_pkg::RESP_OKAY;

  assign cons_arready = 1'b1;
  assign cons_rresp   = axil_pkg::RESP_OKAY;

  // wstrb is ignored, every write covers the whole word
  assign wr_idx  = prod_awaddr[IDX_BITS-1:0];
  assign rd_idx  = cons_araddr[IDX_BITS-1:0];
  assign rd_word = front ? bank1[rd_idx] : bank0[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      front <= 1'b1;
    end else if (swap) begin
      front <= !front;
    end
  end

  // writes land in the back bank
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      if (front) begin
        bank0[wr_idx] <= prod_wdata;
      end else begin
        bank1[wr_idx] <= prod_wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_bvalid <= 1'b0;
    end else if (wr_fire) begin
      prod_bvalid <= 1'b1;
    end else if (prod_bready) begin
      prod_bvalid <= 1'b0;
    end
  end

  // read data stays put while rready is low
  always_ff @(posedge clk) begin
    if (reset) begin
      cons_rvalid <= 1'b0;
    end else if (cons_arvalid) begin
      cons_rvalid <= 1'b1;
    end else if (cons_rready) begin
      cons_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cons_arvalid) begin
      cons_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fb_pixel_stream.sv ====
`timescale 1ns/1ns
`default_nettype none

module fb_pixel_stream #(
  parameter int H_VISIBLE   = 8,
  parameter int V_VISIBLE   = 4,
  parameter int H_TOTAL     = 12,
  parameter int V_TOTAL     = 6,
  parameter int HSYNC_START = 9,
  parameter int HSYNC_LEN   = 2,
  parameter int VSYNC_START = 4,
  parameter int VSYNC_LEN   = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             disp_en,
  input  logic             swap,
  output axil_pkg::addr_t  cons_araddr,
  output logic             cons_arvalid,
  input  logic             cons_arready,
  input  axil_pkg::data_t  cons_rdata,
  input  axil_pkg::resp_t  cons_rresp,
  input  logic             cons_rvalid,
  output logic             cons_rready,
  output logic             pix_out_valid,
  output video_pkg::chan_t red,
  output video_pkg::chan_t grn,
  output video_pkg::chan_t blu,
  output logic             hsync,
  output logic             vsync
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } st_t;

  st_t               state;
  video_pkg::coord_t x;
  video_pkg::coord_t y;
  logic              visible;
  logic              swap_pend;
  logic              slot_done;
  video_pkg::pixel_t shown;

  assign visible = (x < H_VISIBLE) && (y < V_VISIBLE);

  // blank slots still read so every slot takes the same path
  assign cons_araddr  = visible ? axil_pkg::addr_t'(y * H_VISIBLE + x) : '0;
  assign cons_arvalid = (state == ST_ADDR);
  assign cons_rready  = (state == ST_DATA);

  // only OKAY comes back, so rresp does not change what is shown
  assign slot_done     = (state == ST_DATA) && cons_rvalid;
  assign pix_out_valid = slot_done;

  assign shown = visible ? video_pkg::pixel_t'(cons_rdata[video_pkg::PIXEL_BITS-1:0]) : '0;
  assign red   = shown[11:8];
  assign grn   = shown[7:4];
  assign blu   = shown[3:0];

  // sync levels follow the slot position
  assign hsync = (x >= HSYNC_START) && (x < HSYNC_START + HSYNC_LEN);
  assign vsync = (y >= VSYNC_START) && (y < VSYNC_START + VSYNC_LEN);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      swap_pend <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // a swap seen mid-slot costs one extra idle cycle here
          if (swap_pend) begin
            swap_pend <= 1'b0;
          end else if (disp_en && !swap) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (swap) begin
            swap_pend <= 1'b1;
          end
          if (cons_arready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (swap) begin
            swap_pend <= 1'b1;
          end
          if (cons_rvalid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // raster position moves on once per completed read
  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (slot_done) begin
      if (x == H_TOTAL - 1) begin
        x <= '0;
        if (y == V_TOTAL - 1) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/frame_swap_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_swap_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic frame_last,
  input  logic frame_last_taken,
  input  logic wr_idle,
  input  logic vsync,
  output logic swap,
  output logic disp_en
);

  logic last_d;
  logic first_ready;
  logic vsync_q;
  logic vsync_fall;
  logic pend;
  logic req;

  assign vsync_fall = vsync_q && !vsync;

  // first swap once the first frame is in, then one per vsync end
  assign req  = (first_ready && !disp_en) || (disp_en && (pend || vsync_fall));
  assign swap = req && wr_idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_d      <= 1'b0;
      first_ready <= 1'b0;
      vsync_q     <= 1'b0;
      pend        <= 1'b0;
      disp_en     <= 1'b0;
    end else begin
      // frame_last_taken is the pixel handshake on the writer input
      last_d      <= frame_last && frame_last_taken;
      first_ready <= first_ready || last_d;
      vsync_q     <= vsync;
      if (swap) begin
        pend    <= 1'b0;
        disp_en <= 1'b1;
      end else if (disp_en && vsync_fall) begin
        // writer still busy, hold the request
        pend <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/gfx_demo_dbuf.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_dbuf #(
  parameter int H_VISIBLE   = 8,
  parameter int V_VISIBLE   = 4,
  parameter int H_TOTAL     = 12,
  parameter int V_TOTAL     = 6,
  parameter int HSYNC_START = 9,
  parameter int HSYNC_LEN   = 2,
  parameter int VSYNC_START = 4,
  parameter int VSYNC_LEN   = 1,
  parameter int FRAME_WORDS = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  video_pkg::pixel_t pattern_base,
  output logic              pix_out_valid,
  output video_pkg::chan_t  red,
  output video_pkg::chan_t  grn,
  output video_pkg::chan_t  blu,
  output logic              hsync,
  output logic              vsync
);

  // pattern generator to writer
  logic              pix_valid;
  logic              pix_ready;
  axil_pkg::addr_t   pix_addr;
  video_pkg::pixel_t pix_color;
  logic              frame_last;
  logic              pix_taken;

  // write link
  axil_pkg::addr_t   prod_awaddr;
  logic              prod_awvalid;
  logic              prod_awready;
  axil_pkg::data_t   prod_wdata;
  axil_pkg::strb_t   prod_wstrb;
  logic              prod_wvalid;
  logic              prod_wready;
  logic              prod_bvalid;
  axil_pkg::resp_t   prod_bresp;
  logic              prod_bready;

  // read link
  axil_pkg::addr_t   cons_araddr;
  logic              cons_arvalid;
  logic              cons_arready;
  axil_pkg::data_t   cons_rdata;
  axil_pkg::resp_t   cons_rresp;
  logic              cons_rvalid;
  logic              cons_rready;

  logic              wr_idle;
  logic              swap;
  logic              disp_en;

  assign pix_taken = pix_valid && pix_ready;

  test_pattern_gen #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
  ) u_pattern (
    .clk         (clk),
    .reset       (reset),
    .swap        (swap),
    .pattern_base(pattern_base),
    .pix_ready   (pix_ready),
    .pix_valid   (pix_valid),
    .pix_addr    (pix_addr),
    .pix_color   (pix_color),
    .frame_last  (frame_last)
  );

  fb_writer u_writer (
    .clk         (clk),
    .reset       (reset),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix_addr    (pix_addr),
    .pix_color   (pix_color),
    .prod_awaddr (prod_awaddr),
    .prod_awvalid(prod_awvalid),
    .prod_awready(prod_awready),
    .prod_wdata  (prod_wdata),
    .prod_wstrb  (prod_wstrb),
    .prod_wvalid (prod_wvalid),
    .prod_wready (prod_wready),
    .prod_bvalid (prod_bvalid),
    .prod_bresp  (prod_bresp),
    .prod_bready (prod_bready),
    .wr_idle     (wr_idle)
  );

  dbuf_mem_ctrl #(
    .FRAME_WORDS(FRAME_WORDS)
  ) u_mem (
    .clk         (clk),
    .reset       (reset),
    .swap        (swap),
    .prod_awaddr (prod_awaddr),
    .prod_awvalid(prod_awvalid),
    .prod_awready(prod_awready),
    .prod_wdata  (prod_wdata),
    .prod_wstrb  (prod_wstrb),
    .prod_wvalid (prod_wvalid),
    .prod_wready (prod_wready),
    .prod_bvalid (prod_bvalid),
    .prod_bresp  (prod_bresp),
    .prod_bready (prod_bready),
    .cons_araddr (cons_araddr),
    .cons_arvalid(cons_arvalid),
    .cons_arready(cons_arready),
    .cons_rdata  (cons_rdata),
    .cons_rresp  (cons_rresp),
    .cons_rvalid (cons_rvalid),
    .cons_rready (cons_rready)
  );

  fb_pixel_stream #(
    .H_VISIBLE  (H_VISIBLE),
    .V_VISIBLE  (V_VISIBLE),
    .H_TOTAL    (H_TOTAL),
    .V_TOTAL    (V_TOTAL),
    .HSYNC_START(HSYNC_START),
    .HSYNC_LEN  (HSYNC_LEN),
    .VSYNC_START(VSYNC_START),
    .VSYNC_LEN  (VSYNC_LEN)
  ) u_stream (
    .clk          (clk),
    .reset        (reset),
    .disp_en      (disp_en),
    .swap         (swap),
    .cons_araddr  (cons_araddr),
    .cons_arvalid (cons_arvalid),
    .cons_arready (cons_arready),
    .cons_rdata   (cons_rdata),
    .cons_rresp   (cons_rresp),
    .cons_rvalid  (cons_rvalid),
    .cons_rready  (cons_rready),
    .pix_out_valid(pix_out_valid),
    .red          (red),
    .grn          (grn),
    .blu          (blu),
    .hsync        (hsync),
    .vsync        (vsync)
  );

  frame_swap_ctrl u_swap (
    .clk             (clk),
    .reset           (reset),
    .frame_last      (frame_last),
    .frame_last_taken(pix_taken),
    .wr_idle         (wr_idle),
    .vsync           (vsync),
    .swap            (swap),
    .disp_en         (disp_en)
  );

endmodule

`default_nettype wire

// ==== test/gfx_demo_dbuf_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_dbuf_props (
  input logic            clk,
  input logic            reset,
  input logic            swap,
  input logic            wr_quiet,
  input axil_pkg::addr_t awaddr,
  input logic            awvalid,
  input logic            awready,
  input axil_pkg::data_t wdata,
  input logic            wvalid,
  input logic            wready,
  input logic            bvalid,
  input logic            bready,
  input axil_pkg::addr_t araddr,
  input logic            arvalid,
  input logic            arready,
  input axil_pkg::data_t rdata,
  input logic            rvalid,
  input logic            rready
);

  // valid and payload hold until the handshake
  aw_hold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("write address dropped or changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("write data dropped or changed before wready");

  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("write response dropped before bready");

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("read address dropped or changed before arready");

  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read data dropped or changed before rready");

  // read data one cycle after the address
  r_follows_ar: assert property (@(posedge clk) disable iff (reset)
    arvalid && arready |=> rvalid)
    else $error("rvalid did not follow an accepted read address");

  // banks only change roles with no write in flight
  swap_safe: assert property (@(posedge clk) disable iff (reset)
    swap |-> !awvalid && !wvalid && !bvalid)
    else $error("bank swap while a write is in flight");

  quiet_means_idle: assert property (@(posedge clk) disable iff (reset)
    wr_quiet |-> !awvalid && !wvalid && !bvalid)
    else $error("writer idle with a write channel still active");

endmodule

`default_nettype wire

// ==== test/gfx_demo_dbuf_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_dbuf_tb;

  localparam int H_VISIBLE   = 8;
  localparam int V_VISIBLE   = 4;
  localparam int H_TOTAL     = 12;
  localparam int V_TOTAL     = 6;
  localparam int HSYNC_START = 9;
  localparam int HSYNC_LEN   = 2;
  localparam int VSYNC_START = 4;
  localparam int VSYNC_LEN   = 1;
  localparam int FRAME_WORDS = 32;
  localparam int SLOTS       = H_TOTAL * V_TOTAL;

  localparam int SEED          = 91360;
  localparam int RESET_BASE    = 'h0a5;
  localparam int FIRST_TIMEOUT = 2000;
  localparam int SLOT_TIMEOUT  = 40;

  logic              clk;
  logic              reset;
  video_pkg::pixel_t pattern_base;
  logic              pix_out_valid;
  video_pkg::chan_t  red;
  video_pkg::chan_t  grn;
  video_pkg::chan_t  blu;
  logic              hsync;
  logic              vsync;

  // columns of the data file
  int drive_q[$];
  int expect_q[$];

  int   drive_next;
  int   drive_delay;
  int   frame_idx;
  int   pulses_since_fall;
  logic fall_seen;
  logic vsync_prev;

  gfx_demo_dbuf #(
    .H_VISIBLE  (H_VISIBLE),
    .V_VISIBLE  (V_VISIBLE),
    .H_TOTAL    (H_TOTAL),
    .V_TOTAL    (V_TOTAL),
    .HSYNC_START(HSYNC_START),
    .HSYNC_LEN  (HSYNC_LEN),
    .VSYNC_START(VSYNC_START),
    .VSYNC_LEN  (VSYNC_LEN),
    .FRAME_WORDS(FRAME_WORDS)
  ) i_dut (
    .clk          (clk),
    .reset        (reset),
    .pattern_base (pattern_base),
    .pix_out_valid(pix_out_valid),
    .red          (red),
    .grn          (grn),
    .blu          (blu),
    .hsync        (hsync),
    .vsync        (vsync)
  );

  // controller sees both links, so it carries the swap safety check
  bind dbuf_mem_ctrl gfx_demo_dbuf_props i_mem_props (
    .clk     (clk),
    .reset   (reset),
    .swap    (swap),
    .wr_quiet(1'b0),
    .awaddr  (prod_awaddr),
    .awvalid (prod_awvalid),
    .awready (prod_awready),
    .wdata   (prod_wdata),
    .wvalid  (prod_wvalid),
    .wready  (prod_wready),
    .bvalid  (prod_bvalid),
    .bready  (prod_bready),
    .araddr  (cons_araddr),
    .arvalid (cons_arvalid),
    .arready (cons_arready),
    .rdata   (cons_rdata),
    .rvalid  (cons_rvalid),
    .rready  (cons_rready)
  );

  // writer side, read link and swap tied off
  bind fb_writer gfx_demo_dbuf_props i_wr_props (
    .clk     (clk),
    .reset   (reset),
    .swap    (1'b0),
    .wr_quiet(wr_idle),
    .awaddr  (prod_awaddr),
    .awvalid (prod_awvalid),
    .awready (prod_awready),
    .wdata   (prod_wdata),
    .wvalid  (prod_wvalid),
    .wready  (prod_wready),
    .bvalid  (prod_bvalid),
    .bready  (prod_bready),
    .araddr  ('0),
    .arvalid (1'b0),
    .arready (1'b0),
    .rdata   ('0),
    .rvalid  (1'b0),
    .rready  (1'b0)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string test, input int frame, input int x, input int y,
                             input int expected, input int actual);
    assert (expected == actual) else begin
      $display("Fail %s frame %0d slot (%0d,%0d) expected %h actual %h",
               test, frame, x, y, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      stop_with_failure();
    end
  endtask

  // one clock: drive on the rising edge, sample on the falling edge
  task automatic step_cycle();
    @(posedge clk);
    if (drive_delay == 1) begin
      pattern_base <= video_pkg::pixel_t'(drive_next);
    end
    if (drive_delay > 0) begin
      drive_delay = drive_delay - 1;
    end
    @(negedge clk);
    if (vsync_prev && !vsync) begin
      if (fall_seen) begin
        check_value("frame_length", frame_idx, 0, 0, SLOTS, pulses_since_fall);
      end
      fall_seen         = 1'b1;
      pulses_since_fall = 0;
    end
    if (pix_out_valid) begin
      pulses_since_fall = pulses_since_fall + 1;
    end
    vsync_prev = vsync;
  endtask

  task automatic wait_pulse(input int limit, input logic before_first);
    int waited;
    waited = 0;
    step_cycle();
    while (!pix_out_valid && waited < limit) begin
      if (before_first) begin
        check_value("blank_before_first_frame", 0, 0, 0, 0, {hsync, vsync});
      end
      step_cycle();
      waited = waited + 1;
    end
    check_true(pix_out_valid, $sformatf("no pixel pulse within %0d cycles", limit));
  endtask

  initial begin
    int    fd;
    string line;
    int    d_val;
    int    e_val;
    int    rule_base;
    int    x;
    int    y;
    int    exp_color;
    int    seed_val;
    logic  first;

    seed_val          = $urandom(SEED);
    reset             = 1'b1;
    pattern_base      = video_pkg::pixel_t'(RESET_BASE);
    drive_next        = RESET_BASE;
    drive_delay       = 0;
    frame_idx         = 0;
    pulses_since_fall = 0;
    fall_seen         = 1'b0;
    vsync_prev        = 1'b0;

    fd = $fopen("test/frame_input.txt", "r");
    check_true(fd != 0, "cannot open test/frame_input.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%h %h", d_val, e_val) == 2) begin
          drive_q.push_back(d_val);
          expect_q.push_back(e_val);
        end
      end
    end
    $fclose(fd);
    check_true(drive_q.size() > 0, "data file holds no frame lines");

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (frame_idx = 0; frame_idx < drive_q.size(); frame_idx++) begin
      // a frame shows the base driven two frames before it
      if (frame_idx < 2) begin
        rule_base = RESET_BASE;
      end else begin
        rule_base = drive_q[frame_idx - 2];
      end
      check_value("file_expected_base", frame_idx, 0, 0, rule_base, expect_q[frame_idx]);

      for (int s = 0; s < SLOTS; s++) begin
        first = (frame_idx == 0) && (s == 0);
        wait_pulse(first ? FIRST_TIMEOUT : SLOT_TIMEOUT, first);
        x = s % H_TOTAL;
        y = s / H_TOTAL;
        if (s == 0) begin
          drive_next  = drive_q[frame_idx];
          drive_delay = 1 + ($urandom % 8);
        end

        if (x < H_VISIBLE && y < V_VISIBLE) begin
          exp_color = (expect_q[frame_idx] + y * H_VISIBLE + x) % 4096;
          check_value("pixel_color", frame_idx, x, y, exp_color, {red, grn, blu});
        end else begin
          check_value("blank_color", frame_idx, x, y, 0, {red, grn, blu});
        end
        check_value("hsync", frame_idx, x, y,
                    (x >= HSYNC_START && x < HSYNC_START + HSYNC_LEN), hsync);
        check_value("vsync", frame_idx, x, y,
                    (y >= VSYNC_START && y < VSYNC_START + VSYNC_LEN), vsync);
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/frame_input.txt ====
# columns: base driven during displayed frame i, expected base of frame i (hex)
# frames 0 and 1 show the reset base 0a5, frame i+2 shows the base driven in frame i
3c0 0a5
fff 0a5
012 3c0
ff0 fff
800 012
7e5 ff0
000 800
abc 7e5
fe8 000
555 abc
123 fe8
9f0 555
0a5 123
246 9f0

// ==== tb.f ====
logic/video_pkg.sv
logic/axil_pkg.sv
logic/test_pattern_gen.sv
logic/fb_writer.sv
logic/dbuf_mem_ctrl.sv
logic/fb_pixel_stream.sv
logic/frame_swap_ctrl.sv
logic/gfx_demo_dbuf.sv
test/gfx_demo_dbuf_props.sv
test/gfx_demo_dbuf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gfx_demo_dbuf_tb \
  -f tb.f -o gfx_demo_dbuf_sim \
  && ./obj_dir/gfx_demo_dbuf_sim \
  || { echo "build or simulation error" >&2; exit 1; }
